// File: alu_macros.svh
// ==================================================
// Fixed sizes of the integer execution slice
// Included by the package and by any module that
// needs a width, a register count or a table size
// ==================================================

`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// Width of every data word and of the instruction word
`define ALU_WORD_W 32

// Register file holds sixteen registers
`define ALU_REG_COUNT 16

// Four address bits select one of the sixteen registers
`define ALU_REG_ADDR_W 4

// Top significand bits that index the reciprocal table
`define ALU_RECIP_BITS 6

`endif

// File: alu_pkg.sv
// ==================================================
// Types, opcodes and instruction layout shared by
// the decode, execute and result stages
// ==================================================

`default_nettype none

`include "alu_macros.svh"

package alu_pkg;

	// Plain vectors for the widths that carry a meaning
	typedef logic [`ALU_WORD_W-1:0] word_t;
	typedef logic [`ALU_REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [5:0] alu_op_t;
	typedef logic [`ALU_WORD_W-1:0] instr_t;

	// Opcodes, numbered in encoding order. Codes 25 and up are undefined
	localparam alu_op_t OP_OR = 6'd0;
	localparam alu_op_t OP_AND = 6'd1;
	localparam alu_op_t OP_UMINUS = 6'd2;
	localparam alu_op_t OP_XOR = 6'd3;
	localparam alu_op_t OP_NOT = 6'd4;
	localparam alu_op_t OP_IADD = 6'd5;
	localparam alu_op_t OP_ISUB = 6'd6;
	localparam alu_op_t OP_ASR = 6'd7;
	localparam alu_op_t OP_LSR = 6'd8;
	localparam alu_op_t OP_LSL = 6'd9;
	localparam alu_op_t OP_CLZ = 6'd10;
	localparam alu_op_t OP_CTZ = 6'd11;
	localparam alu_op_t OP_COPY = 6'd12;
	localparam alu_op_t OP_EQUAL = 6'd13;
	localparam alu_op_t OP_NEQUAL = 6'd14;
	localparam alu_op_t OP_SIGTR = 6'd15;
	localparam alu_op_t OP_SIGTE = 6'd16;
	localparam alu_op_t OP_SILT = 6'd17;
	localparam alu_op_t OP_SILTE = 6'd18;
	localparam alu_op_t OP_UIGTR = 6'd19;
	localparam alu_op_t OP_UIGTE = 6'd20;
	localparam alu_op_t OP_UILT = 6'd21;
	localparam alu_op_t OP_UILTE = 6'd22;
	localparam alu_op_t OP_RECIP = 6'd23;
	localparam alu_op_t OP_FTOI = 6'd24;

	// Instruction fields, given by their lowest bit
	localparam int OPCODE_LSB = 26;
	localparam int DEST_LSB = 22;
	localparam int SRC1_LSB = 18;
	localparam int SRC2_LSB = 14;
	localparam int IMM_SEL_BIT = 13;
	// Signed immediate sits in bits 12 down to 0
	localparam int IMM_MSB = 12;
	localparam int IMM_W = 13;

endpackage

`default_nettype wire

// File: alu_decode.sv
// ==================================================
// Decode stage. Latches the incoming instruction,
// reads both sources with forwarding from execute,
// then registers the operation for the next cycle
// ==================================================

`default_nettype none

module alu_decode (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic instr_valid,
	input wire alu_pkg::instr_t instr,
	output alu_pkg::reg_addr_t rf_read_a_addr,
	output alu_pkg::reg_addr_t rf_read_b_addr,
	input wire alu_pkg::word_t rf_read_a_data,
	input wire alu_pkg::word_t rf_read_b_data,
	input wire alu_pkg::word_t single_cycle_result,
	output logic ds_valid,
	output alu_pkg::reg_addr_t ds_dest,
	output alu_pkg::alu_op_t ds_alu_op,
	output alu_pkg::word_t operand1,
	output alu_pkg::word_t operand2
);

	import alu_pkg::*;

	// Instruction as captured on the sampling edge
	logic if_valid;
	instr_t if_instr;

	// Fields of the captured instruction
	alu_op_t if_op;
	reg_addr_t if_dest;
	logic if_imm_sel;
	word_t if_imm;

	// Source values after forwarding
	logic fwd_a;
	logic fwd_b;
	word_t src1_value;
	word_t src2_value;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			if_valid <= 1'b0;
			if_instr <= '0;
		end
		else
		begin
			if_valid <= instr_valid;
			if_instr <= instr;
		end
	end

	// Split the instruction word into its fields
	assign if_op = if_instr[OPCODE_LSB +: $bits(alu_op_t)];
	assign if_dest = if_instr[DEST_LSB +: $bits(reg_addr_t)];
	assign if_imm_sel = if_instr[IMM_SEL_BIT];
	// The immediate is sign extended to a full word
	assign if_imm = {{($bits(word_t) - IMM_W){if_instr[IMM_MSB]}}, if_instr[IMM_MSB:0]};

	// Register file is read while the instruction waits in this stage
	assign rf_read_a_addr = if_instr[SRC1_LSB +: $bits(reg_addr_t)];
	assign rf_read_b_addr = if_instr[SRC2_LSB +: $bits(reg_addr_t)];

	// The instruction now in execute is written back only at the next edge,
	// so a read of its destination takes the execute result instead
	assign fwd_a = ds_valid && (ds_dest == rf_read_a_addr);
	assign fwd_b = ds_valid && (ds_dest == rf_read_b_addr);
	assign src1_value = fwd_a ? single_cycle_result : rf_read_a_data;
	assign src2_value = fwd_b ? single_cycle_result : rf_read_b_data;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ds_valid <= 1'b0;
			ds_dest <= '0;
			ds_alu_op <= '0;
			operand1 <= '0;
			operand2 <= '0;
		end
		else
		begin
			ds_valid <= if_valid;
			ds_dest <= if_dest;
			ds_alu_op <= if_op;
			operand1 <= src1_value;
			// Immediate select picks the second operand
			operand2 <= if_imm_sel ? if_imm : src2_value;
		end
	end

endmodule

`default_nettype wire

// File: alu_recip_estimate.sv
// ==================================================
// Single-precision reciprocal estimate with a small
// lookup table indexed by the top fraction bits
// ==================================================

`default_nettype none

`include "alu_macros.svh"

module alu_recip_estimate (
	input wire alu_pkg::word_t value,
	output alu_pkg::word_t estimate
);

	localparam int FRAC_IDX_W = `ALU_RECIP_BITS;
	localparam int TABLE_SIZE = 1 << FRAC_IDX_W;
	// Numerator chosen so that 1/(1 + i/64) lands back in 6 bits
	localparam int RECIP_NUM = 1 << (2 * FRAC_IDX_W + 1);

	typedef logic [FRAC_IDX_W-1:0] frac_idx_t;
	typedef logic [TABLE_SIZE-1:0][FRAC_IDX_W-1:0] recip_table_t;

	// Entry zero is never read, an index of zero is an exact power of two
	function automatic recip_table_t build_recip_table();
		recip_table_t table_v;
		table_v = '0;
		for (int i = 1; i < TABLE_SIZE; i++)
			table_v[i] = frac_idx_t'(RECIP_NUM / (TABLE_SIZE + i) - TABLE_SIZE);
		return table_v;
	endfunction

	localparam recip_table_t RECIP_TABLE = build_recip_table();

	logic sign;
	logic [7:0] exponent;
	frac_idx_t frac_idx;

	assign sign = value[31];
	assign exponent = value[30:23];
	assign frac_idx = value[22 -: FRAC_IDX_W];

	always_comb
	begin
		// Zero exponent reads as zero, so return infinity of the same sign
		if (exponent == 8'd0)
			estimate = {sign, 8'hff, 23'h0};
		// Power of two inverts exactly
		else if (frac_idx == '0)
			estimate = {sign, 8'd254 - exponent, 23'h0};
		// Otherwise the reciprocal falls one binade lower
		else
			estimate = {sign, 8'd253 - exponent, RECIP_TABLE[frac_idx],
				{(23 - FRAC_IDX_W){1'b0}}};
	end

endmodule

`default_nettype wire

// File: alu_single_cycle.sv
// ==================================================
// Execute stage. Computes every supported operation
// in one cycle and leaves the result unregistered
// ==================================================

`default_nettype none

`include "alu_macros.svh"

module alu_single_cycle (
	input wire alu_pkg::alu_op_t ds_alu_op,
	input wire alu_pkg::word_t operand1,
	input wire alu_pkg::word_t operand2,
	output alu_pkg::word_t single_cycle_result
);

	import alu_pkg::*;

	// Shared adder that subtracts for everything except add
	logic do_subtract;
	logic carry_out;
	word_t sum_difference;
	logic zero;
	logic overflow;
	logic signed_lt;
	logic unsigned_lt;

	assign do_subtract = ds_alu_op != OP_IADD;
	assign {carry_out, sum_difference} = {1'b0, operand1}
		+ {1'b0, operand2 ^ {`ALU_WORD_W{do_subtract}}} + word_t'(do_subtract);

	// Flags only mean something when subtracting
	assign zero = sum_difference == '0;
	// Operands of opposite sign and result sign differing from operand1
	assign overflow = (operand1[31] != operand2[31]) && (sum_difference[31] != operand1[31]);
	assign signed_lt = sum_difference[31] ^ overflow;
	// No carry out of a subtraction means a borrow
	assign unsigned_lt = ~carry_out;

	// Trailing zero count of operand2 by halving the search window
	logic [4:0] trailing_zeroes;
	logic [15:0] tz_val16;
	logic [7:0] tz_val8;
	logic [3:0] tz_val4;

	assign trailing_zeroes[4] = operand2[15:0] == 16'h0;
	assign tz_val16 = trailing_zeroes[4] ? operand2[31:16] : operand2[15:0];
	assign trailing_zeroes[3] = tz_val16[7:0] == 8'h0;
	assign tz_val8 = trailing_zeroes[3] ? tz_val16[15:8] : tz_val16[7:0];
	assign trailing_zeroes[2] = tz_val8[3:0] == 4'h0;
	assign tz_val4 = trailing_zeroes[2] ? tz_val8[7:4] : tz_val8[3:0];
	assign trailing_zeroes[1] = tz_val4[1:0] == 2'b0;
	assign trailing_zeroes[0] = trailing_zeroes[1] ? ~tz_val4[2] : ~tz_val4[0];

	// Leading zero count works the same way from the top end
	logic [4:0] leading_zeroes;
	logic [15:0] lz_val16;
	logic [7:0] lz_val8;
	logic [3:0] lz_val4;

	assign leading_zeroes[4] = operand2[31:16] == 16'h0;
	assign lz_val16 = leading_zeroes[4] ? operand2[15:0] : operand2[31:16];
	assign leading_zeroes[3] = lz_val16[15:8] == 8'h0;
	assign lz_val8 = leading_zeroes[3] ? lz_val16[7:0] : lz_val16[15:8];
	assign leading_zeroes[2] = lz_val8[7:4] == 4'h0;
	assign lz_val4 = leading_zeroes[2] ? lz_val8[3:0] : lz_val8[7:4];
	assign leading_zeroes[1] = lz_val4[3:2] == 2'b0;
	assign leading_zeroes[0] = leading_zeroes[1] ? ~lz_val4[1] : ~lz_val4[3];

	// Float fields of operand2 for the conversion
	logic fp_sign;
	logic [7:0] fp_exponent;
	logic [7:0] ftoi_shift;
	word_t fp_significand;

	assign fp_sign = operand2[31];
	assign fp_exponent = operand2[30:23];
	// Hidden one restored above the fraction
	assign fp_significand = {8'h0, 1'b1, operand2[22:0]};
	// Significand is already scaled by 2^23, so the shift is 150 minus exponent
	assign ftoi_shift = 8'd150 - fp_exponent;

	// One right shifter serves LSR, ASR and the conversion alignment
	logic is_ftoi;
	logic [4:0] shift_amount;
	word_t shift_in;
	logic shift_fill;
	logic shift_too_far;
	logic [2*`ALU_WORD_W-1:0] rshift_wide;
	word_t rshift;

	assign is_ftoi = ds_alu_op == OP_FTOI;
	assign shift_amount = is_ftoi ? ftoi_shift[4:0] : operand2[4:0];
	assign shift_in = is_ftoi ? fp_significand : operand1;
	assign shift_fill = (ds_alu_op == OP_ASR) && operand1[31];
	assign rshift_wide = {{`ALU_WORD_W{shift_fill}}, shift_in} >> shift_amount;
	assign rshift = rshift_wide[`ALU_WORD_W-1:0];
	// Any amount bit above bit 4 puts the shift at 32 or beyond
	assign shift_too_far = operand2[31:5] != '0;

	word_t reciprocal;

	alu_recip_estimate u_recip (
		.value(operand2),
		.estimate(reciprocal)
	);

	always_comb
	begin
		case (ds_alu_op)
			OP_OR: single_cycle_result = operand1 | operand2;
			OP_AND: single_cycle_result = operand1 & operand2;
			OP_UMINUS: single_cycle_result = -operand2;
			OP_XOR: single_cycle_result = operand1 ^ operand2;
			OP_NOT: single_cycle_result = ~operand2;
			OP_IADD, OP_ISUB: single_cycle_result = sum_difference;
			// Overlong right shifts leave only the fill bits
			OP_ASR, OP_LSR: single_cycle_result = shift_too_far ? {`ALU_WORD_W{shift_fill}} : rshift;
			OP_LSL: single_cycle_result = shift_too_far ? '0 : operand1 << operand2[4:0];
			OP_CLZ: single_cycle_result = (operand2 == '0) ? 32'd32 : word_t'(leading_zeroes);
			OP_CTZ: single_cycle_result = (operand2 == '0) ? 32'd32 : word_t'(trailing_zeroes);
			OP_COPY: single_cycle_result = operand2;
			// Comparisons return 0 or 1
			OP_EQUAL: single_cycle_result = word_t'(zero);
			OP_NEQUAL: single_cycle_result = word_t'(!zero);
			OP_SIGTR: single_cycle_result = word_t'(!signed_lt && !zero);
			OP_SIGTE: single_cycle_result = word_t'(!signed_lt);
			OP_SILT: single_cycle_result = word_t'(signed_lt);
			OP_SILTE: single_cycle_result = word_t'(signed_lt | zero);
			OP_UIGTR: single_cycle_result = word_t'(!unsigned_lt && !zero);
			OP_UIGTE: single_cycle_result = word_t'(!unsigned_lt);
			OP_UILT: single_cycle_result = word_t'(unsigned_lt);
			OP_UILTE: single_cycle_result = word_t'(unsigned_lt | zero);
			OP_RECIP: single_cycle_result = reciprocal;
			OP_FTOI:
			begin
				// Magnitude below one truncates to zero
				if (fp_exponent < 8'd127)
					single_cycle_result = '0;
				else if (fp_sign)
					single_cycle_result = -rshift;
				else
					single_cycle_result = rshift;
			end
			// Undefined opcodes
			default: single_cycle_result = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: alu_result.sv
// ==================================================
// Result stage. Registers each valid result, writes
// it to the register file and shows it for a cycle
// ==================================================

`default_nettype none

`include "alu_macros.svh"

module alu_result (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic ds_valid,
	input wire alu_pkg::reg_addr_t ds_dest,
	input wire alu_pkg::word_t single_cycle_result,
	input wire alu_pkg::reg_addr_t rf_read_a_addr,
	input wire alu_pkg::reg_addr_t rf_read_b_addr,
	output alu_pkg::word_t rf_read_a_data,
	output alu_pkg::word_t rf_read_b_data,
	output logic result_valid,
	output alu_pkg::reg_addr_t result_reg,
	output alu_pkg::word_t result_data
);

	import alu_pkg::*;

	// Sixteen general registers, all writable
	word_t regs [`ALU_REG_COUNT];

	// Written on the same edge as the result register
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < `ALU_REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (ds_valid)
			regs[ds_dest] <= single_cycle_result;
	end

	// Two read ports, decode handles the write of the same cycle by forwarding
	assign rf_read_a_data = regs[rf_read_a_addr];
	assign rf_read_b_data = regs[rf_read_b_addr];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			result_valid <= 1'b0;
			result_reg <= '0;
			result_data <= '0;
		end
		else
		begin
			result_valid <= ds_valid;
			// Hold the last result while no new one arrives
			if (ds_valid)
			begin
				result_reg <= ds_dest;
				result_data <= single_cycle_result;
			end
		end
	end

endmodule

`default_nettype wire

// File: alu_core.sv
// ==================================================
// Top level of the execution slice. One instruction
// per cycle in, its result two cycles later out
// ==================================================

`default_nettype none

module alu_core (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic instr_valid,
	input wire alu_pkg::instr_t instr,
	output logic result_valid,
	output alu_pkg::reg_addr_t result_reg,
	output alu_pkg::word_t result_data
);

	import alu_pkg::*;

	// Decode outputs into execute and result
	logic ds_valid;
	reg_addr_t ds_dest;
	alu_op_t ds_alu_op;
	word_t operand1;
	word_t operand2;

	// Execute result, also forwarded back to decode
	word_t single_cycle_result;

	// Register file read ports
	reg_addr_t rf_read_a_addr;
	reg_addr_t rf_read_b_addr;
	word_t rf_read_a_data;
	word_t rf_read_b_data;

	alu_decode u_decode (
		.clk(clk),
		.arst_n(arst_n),
		.instr_valid(instr_valid),
		.instr(instr),
		.rf_read_a_addr(rf_read_a_addr),
		.rf_read_b_addr(rf_read_b_addr),
		.rf_read_a_data(rf_read_a_data),
		.rf_read_b_data(rf_read_b_data),
		.single_cycle_result(single_cycle_result),
		.ds_valid(ds_valid),
		.ds_dest(ds_dest),
		.ds_alu_op(ds_alu_op),
		.operand1(operand1),
		.operand2(operand2)
	);

	alu_single_cycle u_execute (
		.ds_alu_op(ds_alu_op),
		.operand1(operand1),
		.operand2(operand2),
		.single_cycle_result(single_cycle_result)
	);

	alu_result u_result (
		.clk(clk),
		.arst_n(arst_n),
		.ds_valid(ds_valid),
		.ds_dest(ds_dest),
		.single_cycle_result(single_cycle_result),
		.rf_read_a_addr(rf_read_a_addr),
		.rf_read_b_addr(rf_read_b_addr),
		.rf_read_a_data(rf_read_a_data),
		.rf_read_b_data(rf_read_b_data),
		.result_valid(result_valid),
		.result_reg(result_reg),
		.result_data(result_data)
	);

endmodule

`default_nettype wire

// File: alu_tb_clock.sv
// ==================================================
// Testbench clock and reset. Free running 10 ns
// clock, reset held low for the first 16 cycles
// ==================================================

`default_nettype none

module alu_tb_clock (
	output logic clk,
	output logic arst_n
);

	timeunit 1ns;
	timeprecision 1ps;

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Reset is released on a falling edge, away from the flop sampling edge
	initial
	begin
		arst_n = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: alu_properties.sv
// ==================================================
// Concurrent checks on the slice top level, attached
// to every alu_core instance through bind
// ==================================================

`default_nettype none

module alu_properties (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic instr_valid,
	input wire logic result_valid,
	input wire alu_pkg::word_t result_data
);

	timeunit 1ns;
	timeprecision 1ps;

	// Nothing leaves the result stage while reset holds
	reset_quiet: assert property (@(posedge clk) !arst_n |-> !result_valid)
		else $error("result_valid is high while reset is active");

	// The strobe rises two cycles after the sampling edge, so its sampled
	// value trails the sampled instr_valid by three edges
	fixed_latency: assert property (@(posedge clk) disable iff (!arst_n)
		result_valid == $past(instr_valid, 3))
		else $error("result_valid does not follow instr_valid by two cycles");

	// A reported result is always fully driven
	known_result: assert property (@(posedge clk) disable iff (!arst_n)
		result_valid |-> !$isunknown(result_data))
		else $error("result_data is unknown while result_valid is high");

endmodule

bind alu_core alu_properties u_properties (
	.clk(clk),
	.arst_n(arst_n),
	.instr_valid(instr_valid),
	.result_valid(result_valid),
	.result_data(result_data)
);

`default_nettype wire

// File: alu_tb.sv
// ==================================================
// Directed testbench for the execution slice. Each
// test is a task. Results are checked in issue order
// against a sequential reference model
// ==================================================

`default_nettype none

`include "alu_macros.svh"

module alu_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import alu_pkg::*;

	logic clk;
	logic arst_n;
	logic instr_valid;
	instr_t instr;
	logic result_valid;
	reg_addr_t result_reg;
	word_t result_data;

	// Reference register file that is updated in program order at issue time
	word_t model_rf [`ALU_REG_COUNT];

	// Outstanding results in issue order with the cycle each must show up
	reg_addr_t exp_reg_q [$];
	word_t exp_data_q [$];
	int exp_cycle_q [$];

	int cycle;
	int checks;
	int errors;
	int tests;
	int test_errors_start;
	string test_name;

	alu_tb_clock u_clock (
		.clk(clk),
		.arst_n(arst_n)
	);

	alu_core u_alu_core (
		.clk(clk),
		.arst_n(arst_n),
		.instr_valid(instr_valid),
		.instr(instr),
		.result_valid(result_valid),
		.result_reg(result_reg),
		.result_data(result_data)
	);

	always @(posedge clk)
		cycle <= cycle + 1;

	task automatic check_value(string what, word_t expected, word_t actual);
		checks++;
		assert (expected == actual)
		else
		begin
			errors++;
			$display("MISMATCH %s %s expected %h actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic confirm(logic ok, string what);
		checks++;
		assert (ok)
		else
		begin
			errors++;
			$display("%s failed: %s", test_name, what);
		end
	endtask

	// Results are compared on the falling edge where the outputs are settled
	always @(negedge clk)
	begin
		if (arst_n && result_valid)
		begin
			confirm(exp_reg_q.size() != 0, "result_valid rose with nothing outstanding");
			if (exp_reg_q.size() != 0)
			begin
				check_value("result_reg", word_t'(exp_reg_q.pop_front()), word_t'(result_reg));
				check_value("result_data", exp_data_q.pop_front(), result_data);
				check_value("result cycle", word_t'(exp_cycle_q.pop_front()), word_t'(cycle));
			end
		end
	end

	// Reciprocal estimate from the sign, exponent and top six fraction bits
	function automatic word_t reciprocal_estimate(word_t v);
		int idx;
		int exp_v;
		idx = v[22:17];
		exp_v = v[30:23];
		if (exp_v == 0)
			return {v[31], 8'hff, 23'h0};
		if (idx == 0)
			return {v[31], 8'(254 - exp_v), 23'h0};
		return {v[31], 8'(253 - exp_v), 6'(8192 / (64 + idx) - 64), 17'h0};
	endfunction

	function automatic word_t float_to_int(word_t v);
		word_t mag;
		if (v[30:23] < 8'd127)
			return '0;
		mag = {8'h0, 1'b1, v[22:0]} >> (150 - v[30:23]);
		return v[31] ? -mag : mag;
	endfunction

	// Walks from one end until the first set bit. A zero word counts 32
	function automatic word_t count_zeros(word_t v, bit leading);
		int n;
		n = 0;
		for (int i = 0; i < 32; i++)
		begin
			if (v[leading ? 31 - i : i])
				break;
			n++;
		end
		return word_t'(n);
	endfunction

	function automatic word_t predict_result(alu_op_t op, word_t a, word_t b);
		case (op)
			OP_OR: return a | b;
			OP_AND: return a & b;
			OP_UMINUS: return -b;
			OP_XOR: return a ^ b;
			OP_NOT: return ~b;
			OP_IADD: return a + b;
			OP_ISUB: return a - b;
			OP_ASR: return (b >= 32) ? {32{a[31]}} : word_t'($signed(a) >>> b);
			OP_LSR: return (b >= 32) ? '0 : a >> b;
			OP_LSL: return (b >= 32) ? '0 : a << b;
			OP_CLZ: return count_zeros(b, 1'b1);
			OP_CTZ: return count_zeros(b, 1'b0);
			OP_COPY: return b;
			OP_EQUAL: return word_t'(a == b);
			OP_NEQUAL: return word_t'(a != b);
			OP_SIGTR: return word_t'($signed(a) > $signed(b));
			OP_SIGTE: return word_t'($signed(a) >= $signed(b));
			OP_SILT: return word_t'($signed(a) < $signed(b));
			OP_SILTE: return word_t'($signed(a) <= $signed(b));
			OP_UIGTR: return word_t'(a > b);
			OP_UIGTE: return word_t'(a >= b);
			OP_UILT: return word_t'(a < b);
			OP_UILTE: return word_t'(a <= b);
			OP_RECIP: return reciprocal_estimate(b);
			OP_FTOI: return float_to_int(b);
			default: return '0;
		endcase
	endfunction

	function automatic reg_addr_t rand_reg();
		return reg_addr_t'($urandom_range(`ALU_REG_COUNT - 1));
	endfunction

	// Drives one instruction for a single cycle starting on a falling edge
	task automatic issue(alu_op_t op, reg_addr_t dest, reg_addr_t src1, reg_addr_t src2,
		logic imm_sel, logic [12:0] imm);
		word_t b;
		word_t result;
		b = imm_sel ? {{19{imm[12]}}, imm} : model_rf[src2];
		result = predict_result(op, model_rf[src1], b);
		model_rf[dest] = result;
		exp_reg_q.push_back(dest);
		exp_data_q.push_back(result);
		// Sampling edge, decode edge and result edge lie ahead
		exp_cycle_q.push_back(cycle + 3);
		instr_valid = 1'b1;
		instr = {op, dest, src1, src2, imm_sel, imm};
		@(negedge clk);
		instr_valid = 1'b0;
	endtask

	// Builds a full word from 12, 12 and 8 bit immediate pieces
	task automatic load_reg(reg_addr_t r, word_t v);
		issue(OP_COPY, r, 4'd0, 4'd0, 1'b1, {1'b0, v[31:20]});
		issue(OP_LSL, r, r, 4'd0, 1'b1, 13'd12);
		issue(OP_OR, r, r, 4'd0, 1'b1, {1'b0, v[19:8]});
		issue(OP_LSL, r, r, 4'd0, 1'b1, 13'd8);
		issue(OP_OR, r, r, 4'd0, 1'b1, {5'b0, v[7:0]});
	endtask

	task automatic start_test(string name);
		test_name = name;
		test_errors_start = errors;
	endtask

	task automatic finish_test();
		int waited;
		waited = 0;
		while (exp_reg_q.size() != 0 && waited < 20)
		begin
			@(negedge clk);
			waited++;
		end
		confirm(exp_reg_q.size() == 0, "timed out waiting for result_valid");
		exp_reg_q.delete();
		exp_data_q.delete();
		exp_cycle_q.delete();
		tests++;
		$display("%s finished with %0d errors", test_name, errors - test_errors_start);
	endtask

	task automatic reset_and_build();
		start_test("reset_build");
		repeat (4)
		begin
			@(negedge clk);
			confirm(!result_valid, "result_valid high with nothing issued");
			check_value("result_reg after reset", '0, word_t'(result_reg));
			check_value("result_data after reset", '0, result_data);
		end
		for (int r = 0; r < `ALU_REG_COUNT; r++)
		begin
			load_reg(reg_addr_t'(r), $urandom);
			repeat (2) @(negedge clk);
		end
		finish_test();
	endtask

	task automatic arith_and_logic();
		alu_op_t ops [7] = '{OP_IADD, OP_ISUB, OP_UMINUS, OP_NOT, OP_AND, OP_OR, OP_XOR};
		start_test("arith_logic");
		for (int i = 0; i < 60; i++)
		begin
			issue(ops[$urandom_range(6)], rand_reg(), rand_reg(), rand_reg(), 1'($urandom),
				13'($urandom));
			if ($urandom_range(1) == 1)
				@(negedge clk);
		end
		finish_test();
	endtask

	task automatic shifts_and_counts();
		start_test("shift_count");
		for (int amt = 0; amt <= 40; amt++)
		begin
			issue(OP_LSR, rand_reg(), rand_reg(), 4'd0, 1'b1, 13'(amt));
			issue(OP_ASR, rand_reg(), rand_reg(), 4'd0, 1'b1, 13'(amt));
			issue(OP_LSL, rand_reg(), rand_reg(), 4'd0, 1'b1, 13'(amt));
		end
		// Zero operand counts 32 both ways
		issue(OP_CLZ, rand_reg(), 4'd0, 4'd0, 1'b1, 13'd0);
		issue(OP_CTZ, rand_reg(), 4'd0, 4'd0, 1'b1, 13'd0);
		for (int b = 0; b < 32; b++)
		begin
			issue(OP_COPY, 4'd1, 4'd0, 4'd0, 1'b1, 13'd1);
			issue(OP_LSL, 4'd1, 4'd1, 4'd0, 1'b1, 13'(b));
			issue(OP_CLZ, 4'd2, 4'd0, 4'd1, 1'b0, 13'd0);
			issue(OP_CTZ, 4'd3, 4'd0, 4'd1, 1'b0, 13'd0);
		end
		finish_test();
	endtask

	task automatic comparisons();
		alu_op_t op;
		start_test("compare");
		// r12 and r14 get the sign bit set while r13 has it clear
		issue(OP_OR, 4'd12, rand_reg(), 4'd0, 1'b1, 13'h1000);
		issue(OP_LSR, 4'd13, rand_reg(), 4'd0, 1'b1, 13'd1);
		issue(OP_OR, 4'd14, rand_reg(), 4'd0, 1'b1, 13'h1800);
		for (int k = 0; k < 10; k++)
		begin
			op = alu_op_t'(OP_EQUAL + k);
			issue(op, 4'd15, rand_reg(), rand_reg(), 1'b0, 13'd0);
			issue(op, 4'd15, 4'd12, 4'd12, 1'b0, 13'd0);
			issue(op, 4'd15, 4'd12, 4'd13, 1'b0, 13'd0);
			issue(op, 4'd15, 4'd13, 4'd12, 1'b0, 13'd0);
			issue(op, 4'd15, 4'd12, 4'd14, 1'b0, 13'd0);
			issue(op, 4'd15, 4'd14, 4'd12, 1'b0, 13'd0);
			issue(op, 4'd15, rand_reg(), 4'd0, 1'b1, 13'($urandom));
		end
		finish_test();
	endtask

	task automatic dependency_chains();
		alu_op_t ops [8] = '{OP_IADD, OP_ISUB, OP_XOR, OP_OR, OP_AND, OP_NOT, OP_UMINUS, OP_COPY};
		reg_addr_t prev;
		reg_addr_t dest;
		start_test("back_to_back");
		for (int c = 0; c < 8; c++)
		begin
			prev = rand_reg();
			for (int i = 0; i < 12; i++)
			begin
				dest = rand_reg();
				issue(ops[$urandom_range(7)], dest, prev, ($urandom_range(1) == 1) ? prev : rand_reg(),
					1'($urandom_range(3) == 0), 13'($urandom));
				prev = dest;
			end
		end
		finish_test();
	endtask

	task automatic conversions_and_undefined();
		start_test("convert_undefined");
		for (int e = 100; e <= 150; e++)
		begin
			for (int s = 0; s < 2; s++)
			begin
				load_reg(4'd5, {1'(s), 8'(e), 23'($urandom)});
				issue(OP_FTOI, 4'd6, 4'd0, 4'd5, 1'b0, 13'd0);
			end
		end
		for (int i = 0; i < 64; i++)
		begin
			load_reg(4'd7, {1'($urandom), 8'($urandom), 6'(i), 17'($urandom)});
			issue(OP_RECIP, 4'd8, 4'd0, 4'd7, 1'b0, 13'd0);
		end
		load_reg(4'd7, {1'b1, 8'h00, 23'($urandom)});
		issue(OP_RECIP, 4'd8, 4'd0, 4'd7, 1'b0, 13'd0);
		for (int i = 0; i < 16; i++)
			issue(OP_RECIP, rand_reg(), 4'd0, rand_reg(), 1'b0, 13'd0);
		for (int op = 25; op < 64; op++)
			issue(alu_op_t'(op), rand_reg(), rand_reg(), rand_reg(), 1'($urandom), 13'($urandom));
		finish_test();
	endtask

	initial
	begin
		int waited;
		void'($urandom(32'ha77c_d141));
		instr_valid = 1'b0;
		instr = '0;
		cycle = 0;
		checks = 0;
		errors = 0;
		tests = 0;
		test_errors_start = 0;
		test_name = "reset";
		foreach (model_rf[i])
			model_rf[i] = '0;
		waited = 0;
		while (arst_n !== 1'b1 && waited < 40)
		begin
			@(negedge clk);
			waited++;
		end
		confirm(arst_n === 1'b1, "reset was never released");
		reset_and_build();
		arith_and_logic();
		shifts_and_counts();
		comparisons();
		dependency_chains();
		conversions_and_undefined();
		$display("%0d tests run, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
alu_pkg.sv
alu_decode.sv
alu_recip_estimate.sv
alu_single_cycle.sv
alu_result.sv
alu_core.sv
alu_tb_clock.sv
alu_properties.sv
alu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line

rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module alu_tb \
	-f project.f --Mdir obj_dir -o alu_sim > build.log 2>&1 &&
./obj_dir/alu_sim > sim.log 2>&1

cat sim.log 2>/dev/null
grep -qx "TEST PASS" sim.log 2>/dev/null && echo "simulation passed" ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }
